/* rtl/jsp_consts.svh */
`ifndef JSP_CONSTS_SVH
`define JSP_CONSTS_SVH

// Byte FIFO geometry
`define JSP_FIFO_DEPTH 8
// Fill counts must hold 0 through the full depth
`define JSP_CNT_W 4

// 16550 register map, 3-bit Wishbone address
`define JSP_ADR_DATA 3'd0
`define JSP_ADR_IER  3'd1
// Reads as IIR, writes as FCR
`define JSP_ADR_IIR  3'd2
`define JSP_ADR_LCR  3'd3
`define JSP_ADR_MCR  3'd4
`define JSP_ADR_LSR  3'd5
`define JSP_ADR_MSR  3'd6
`define JSP_ADR_SCR  3'd7

// IIR codes, highest priority first
`define JSP_IIR_RX   8'h04
`define JSP_IIR_THRE 8'h02
`define JSP_IIR_NONE 8'h01

`endif

/* rtl/jsp_pkg.sv */
package jsp_pkg;

`include "jsp_consts.svh"

  ////////////////////////////////////////////////////////////
  // Debug host port
  ////////////////////////////////////////////////////////////

  // Host request, strobes last one cycle
  typedef struct packed {
    logic       wr_strobe;
    logic       rd_strobe;
    logic [7:0] data;
  } dbg_req_t;

  // Byte on offer plus fill levels seen by the host
  typedef struct packed {
    logic [7:0]            data;
    logic [`JSP_CNT_W-1:0] bytes_avail;
    logic [`JSP_CNT_W-1:0] bytes_free;
  } dbg_rsp_t;

  ////////////////////////////////////////////////////////////
  // Wishbone slave port
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [2:0] adr;
    logic [7:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       ack;
    logic       err;
  } wb_rsp_t;

  ////////////////////////////////////////////////////////////
  // Byte FIFO control and status
  ////////////////////////////////////////////////////////////

  // en qualifies, push selects push (1) or pop (0)
  typedef struct packed {
    logic en;
    logic push;
  } fifo_cmd_t;

  typedef struct packed {
    logic [`JSP_CNT_W-1:0] avail;
    logic [`JSP_CNT_W-1:0] free;
  } fifo_stat_t;

endpackage

/* rtl/jsp_byte_fifo.sv */
`timescale 1ns/1ps
`include "jsp_consts.svh"

module jsp_byte_fifo (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  logic                clr_i,
  input  jsp_pkg::fifo_cmd_t  cmd_i,
  input  logic [7:0]          data_i,
  output logic [7:0]          data_o,
  output jsp_pkg::fifo_stat_t stat_o
);

  // Pointers wrap on their own, depth is a power of two
  localparam int PTR_W = $clog2(`JSP_FIFO_DEPTH);
  localparam logic [`JSP_CNT_W-1:0] DEPTH = `JSP_CNT_W'(`JSP_FIFO_DEPTH);

  logic [7:0]            mem [`JSP_FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [`JSP_CNT_W-1:0] count;
  logic                  do_push;
  logic                  do_pop;

  // Drop push when full, ignore pop when empty
  assign do_push = cmd_i.en & cmd_i.push & (count != DEPTH);
  assign do_pop  = cmd_i.en & ~cmd_i.push & (count != '0);

  // Storage array
  always_ff @(posedge wb_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clr_i) begin
      // Synchronous flush from FCR
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (do_push) begin
      wr_ptr <= wr_ptr + 1'b1;
      count  <= count + 1'b1;
    end else if (do_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
      count  <= count - 1'b1;
    end
  end

  // Head is always visible
  assign data_o = mem[rd_ptr];

  assign stat_o.avail = count;
  assign stat_o.free  = DEPTH - count;

endmodule

/* rtl/jsp_fifo_ctrl.sv */
`timescale 1ns/1ps

module jsp_fifo_ctrl (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  jsp_pkg::dbg_req_t   dbg_req_i,
  input  logic                bus_rd_i,
  input  logic                bus_wr_i,
  input  jsp_pkg::fifo_stat_t rx_stat_i,
  input  jsp_pkg::fifo_stat_t tx_stat_i,
  input  logic [7:0]          tx_head_i,
  output jsp_pkg::fifo_cmd_t  rx_cmd_o,
  output jsp_pkg::fifo_cmd_t  tx_cmd_o,
  output logic [7:0]          rx_din_o,
  output logic [7:0]          dbg_data_o,
  output logic                data_ack_o
);

  typedef enum logic [1:0] {RX_IDLE, RX_PUSH, RX_POP} rx_state_e;
  typedef enum logic [1:0] {TX_IDLE, TX_PUSH, TX_POP, TX_LATCH} tx_state_e;

  rx_state_e  rx_state;
  rx_state_e  rx_next;
  tx_state_e  tx_state;
  tx_state_e  tx_next;
  logic [7:0] wr_byte;
  logic [7:0] dbg_data;
  logic       wr_pend;
  logic       rd_pend;
  logic       latch_due;
  logic       wr_req;
  logic       pop_req;
  logic       tx_empty;

  ////////////////////////////////////////////////////////////
  // Debug side latches
  ////////////////////////////////////////////////////////////

  // Byte offered by the host
  always_ff @(posedge wb_clk_i) begin
    if (dbg_req_i.wr_strobe) begin
      wr_byte <= dbg_req_i.data;
    end
  end

  // Pending flags, a new strobe wins over the clear
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_pend   <= 1'b0;
      rd_pend   <= 1'b0;
      latch_due <= 1'b0;
    end else begin
      if (dbg_req_i.wr_strobe) begin
        wr_pend <= 1'b1;
      end else if (rx_state == RX_PUSH) begin
        wr_pend <= 1'b0;
      end
      if (dbg_req_i.rd_strobe) begin
        rd_pend <= 1'b1;
      end else if (tx_state == TX_POP) begin
        rd_pend <= 1'b0;
      end
      // A write may cut in right after a pop, head reload still owed
      if (tx_state == TX_POP) begin
        latch_due <= 1'b1;
      end else if (tx_state == TX_LATCH) begin
        latch_due <= 1'b0;
      end
    end
  end

  // Strobe counts as a request in its own cycle
  assign wr_req   = wr_pend | dbg_req_i.wr_strobe;
  assign tx_empty = (tx_stat_i.avail == '0);
  assign pop_req  = (rd_pend | dbg_req_i.rd_strobe) & ~tx_empty;

  ////////////////////////////////////////////////////////////
  // Rx sequencing, bus read first
  ////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      rx_state <= RX_IDLE;
      tx_state <= TX_IDLE;
    end else begin
      rx_state <= rx_next;
      tx_state <= tx_next;
    end
  end

  always_comb begin
    rx_next = RX_IDLE;
    case (rx_state)
      RX_IDLE: begin
        if (bus_rd_i) begin
          rx_next = RX_POP;
        end else if (wr_req) begin
          rx_next = RX_PUSH;
        end
      end
      // Read seen here is always a fresh request
      RX_PUSH: begin
        if (bus_rd_i) begin
          rx_next = RX_POP;
        end
      end
      // Read still held while acked, so no repeat
      RX_POP: begin
        if (wr_req) begin
          rx_next = RX_PUSH;
        end
      end
      default: rx_next = RX_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Tx sequencing, bus write first
  ////////////////////////////////////////////////////////////

  always_comb begin
    tx_next = TX_IDLE;
    case (tx_state)
      TX_IDLE, TX_LATCH: begin
        if (bus_wr_i) begin
          tx_next = TX_PUSH;
        end else if (pop_req) begin
          tx_next = TX_POP;
        end
      end
      TX_PUSH: begin
        // First byte into empty tx, or head owed after a pop
        if (tx_empty || latch_due) begin
          tx_next = TX_LATCH;
        end else if (pop_req) begin
          tx_next = TX_POP;
        end
      end
      TX_POP: begin
        tx_next = bus_wr_i ? TX_PUSH : TX_LATCH;
      end
      default: tx_next = TX_IDLE;
    endcase
  end

  // Byte shown to the host
  always_ff @(posedge wb_clk_i) begin
    if (tx_state == TX_LATCH) begin
      dbg_data <= tx_head_i;
    end
  end

  // FIFO commands
  assign rx_cmd_o.en   = ((rx_state == RX_PUSH) & (rx_stat_i.free != '0)) |
                         ((rx_state == RX_POP) & (rx_stat_i.avail != '0));
  assign rx_cmd_o.push = (rx_state == RX_PUSH);
  assign tx_cmd_o.en   = (tx_state == TX_PUSH) | (tx_state == TX_POP);
  assign tx_cmd_o.push = (tx_state == TX_PUSH);

  assign rx_din_o   = wr_byte;
  assign dbg_data_o = dbg_data;
  // Bus data cycle ends here
  assign data_ack_o = (rx_state == RX_POP) | (tx_state == TX_PUSH);

endmodule

/* rtl/jsp_uart_regs.sv */
`timescale 1ns/1ps
`include "jsp_consts.svh"

module jsp_uart_regs (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  jsp_pkg::wb_req_t    wb_req_i,
  input  logic                data_ack_i,
  input  jsp_pkg::fifo_stat_t rx_stat_i,
  input  jsp_pkg::fifo_stat_t tx_stat_i,
  input  jsp_pkg::fifo_cmd_t  tx_cmd_i,
  input  logic [7:0]          rx_head_i,
  output jsp_pkg::wb_rsp_t    wb_rsp_o,
  output logic                bus_rd_o,
  output logic                bus_wr_o,
  output logic                rx_clr_o,
  output logic                tx_clr_o,
  output logic                int_o
);

  logic [3:0] ier;
  logic [7:0] lcr;
  logic [7:0] scr;
  logic [7:0] lsr;
  logic [7:0] iir;
  logic [7:0] rd_dat;
  logic       thr_arm;
  logic       req;
  logic       data_sel;
  logic       iir_sel;
  logic       iir_read;
  logic       rx_not_empty;
  logic       tx_not_full;
  logic       tx_going_empty;

  ////////////////////////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////////////////////////

  assign req      = wb_req_i.cyc & wb_req_i.stb;
  // DLAB turns address 0 into a plain register
  assign data_sel = (wb_req_i.adr == `JSP_ADR_DATA) & ~lcr[7];
  assign iir_sel  = (wb_req_i.adr == `JSP_ADR_IIR);

  assign bus_rd_o = req & ~wb_req_i.we & data_sel;
  assign bus_wr_o = req & wb_req_i.we & data_sel;
  assign iir_read = req & ~wb_req_i.we & iir_sel;

  // FCR flush bits
  assign rx_clr_o = req & wb_req_i.we & iir_sel & wb_req_i.dat[1];
  assign tx_clr_o = req & wb_req_i.we & iir_sel & wb_req_i.dat[2];

  // Writable registers
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      ier <= '0;
      lcr <= '0;
      scr <= '0;
    end else if (req && wb_req_i.we) begin
      case (wb_req_i.adr)
        `JSP_ADR_IER: begin
          if (!lcr[7]) begin
            ier <= wb_req_i.dat[3:0];
          end
        end
        `JSP_ADR_LCR: lcr <= wb_req_i.dat;
        `JSP_ADR_SCR: scr <= wb_req_i.dat;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Status and interrupt
  ////////////////////////////////////////////////////////////

  assign rx_not_empty = (rx_stat_i.avail != '0);
  assign tx_not_full  = (tx_stat_i.free != '0);
  // Last byte leaving tx
  assign tx_going_empty = tx_cmd_i.en & ~tx_cmd_i.push & (tx_stat_i.avail == 1);

  assign lsr = {1'b0, tx_not_full, tx_not_full, 4'h0, rx_not_empty};

  // THR interrupt arm, an IIR read acknowledges it
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      thr_arm <= 1'b0;
    end else if (bus_wr_o || tx_going_empty) begin
      thr_arm <= 1'b1;
    end else if (iir_read && !rx_not_empty) begin
      thr_arm <= 1'b0;
    end
  end

  always_comb begin
    if (rx_not_empty) begin
      iir = `JSP_IIR_RX;
    end else if (thr_arm && tx_not_full) begin
      iir = `JSP_IIR_THRE;
    end else begin
      iir = `JSP_IIR_NONE;
    end
  end

  assign int_o = (tx_not_full & thr_arm & ier[1]) | (rx_not_empty & ier[0]);

  // Read data mux, address 0 shows rx head in both DLAB states
  always_comb begin
    case (wb_req_i.adr)
      `JSP_ADR_DATA: rd_dat = rx_head_i;
      `JSP_ADR_IER:  rd_dat = {4'h0, ier};
      `JSP_ADR_IIR:  rd_dat = iir;
      `JSP_ADR_LCR:  rd_dat = lcr;
      `JSP_ADR_LSR:  rd_dat = lsr;
      `JSP_ADR_MSR:  rd_dat = 8'h0b;
      `JSP_ADR_SCR:  rd_dat = scr;
      // MCR not implemented
      default:       rd_dat = 8'h00;
    endcase
  end

  // Registers ack at once, data waits for the control module
  assign wb_rsp_o.dat = rd_dat;
  assign wb_rsp_o.ack = (req & ~data_sel) | data_ack_i;
  assign wb_rsp_o.err = 1'b0;

endmodule

/* rtl/jsp_wb_bridge.sv */
`timescale 1ns/1ps

module jsp_wb_bridge (
  input  logic              wb_clk_i,
  input  logic              rst_i,
  input  jsp_pkg::dbg_req_t dbg_req_i,
  input  jsp_pkg::wb_req_t  wb_req_i,
  output jsp_pkg::dbg_rsp_t dbg_rsp_o,
  output jsp_pkg::wb_rsp_t  wb_rsp_o,
  output logic              int_o
);

  jsp_pkg::fifo_cmd_t  rx_cmd;
  jsp_pkg::fifo_cmd_t  tx_cmd;
  jsp_pkg::fifo_stat_t rx_stat;
  jsp_pkg::fifo_stat_t tx_stat;
  logic [7:0]          rx_din;
  logic [7:0]          rx_head;
  logic [7:0]          tx_head;
  logic [7:0]          dbg_data;
  logic                bus_rd;
  logic                bus_wr;
  logic                data_ack;
  logic                rx_clr;
  logic                tx_clr;

  ////////////////////////////////////////////////////////////
  // Sequencing between debug port and bus
  ////////////////////////////////////////////////////////////

  jsp_fifo_ctrl jsp_fifo_ctrl_i (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .dbg_req_i (dbg_req_i),
    .bus_rd_i  (bus_rd),
    .bus_wr_i  (bus_wr),
    .rx_stat_i (rx_stat),
    .tx_stat_i (tx_stat),
    .tx_head_i (tx_head),
    .rx_cmd_o  (rx_cmd),
    .tx_cmd_o  (tx_cmd),
    .rx_din_o  (rx_din),
    .dbg_data_o(dbg_data),
    .data_ack_o(data_ack)
  );

  // Debug host to bus
  jsp_byte_fifo rx_fifo (
    .wb_clk_i(wb_clk_i),
    .rst_i   (rst_i),
    .clr_i   (rx_clr),
    .cmd_i   (rx_cmd),
    .data_i  (rx_din),
    .data_o  (rx_head),
    .stat_o  (rx_stat)
  );

  // Bus to debug host, fed straight from write data
  jsp_byte_fifo tx_fifo (
    .wb_clk_i(wb_clk_i),
    .rst_i   (rst_i),
    .clr_i   (tx_clr),
    .cmd_i   (tx_cmd),
    .data_i  (wb_req_i.dat),
    .data_o  (tx_head),
    .stat_o  (tx_stat)
  );

  jsp_uart_regs jsp_uart_regs_i (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .wb_req_i  (wb_req_i),
    .data_ack_i(data_ack),
    .rx_stat_i (rx_stat),
    .tx_stat_i (tx_stat),
    .tx_cmd_i  (tx_cmd),
    .rx_head_i (rx_head),
    .wb_rsp_o  (wb_rsp_o),
    .bus_rd_o  (bus_rd),
    .bus_wr_o  (bus_wr),
    .rx_clr_o  (rx_clr),
    .tx_clr_o  (tx_clr),
    .int_o     (int_o)
  );

  // Host reads from tx and writes into rx
  assign dbg_rsp_o.data        = dbg_data;
  assign dbg_rsp_o.bytes_avail = tx_stat.avail;
  assign dbg_rsp_o.bytes_free  = rx_stat.free;

endmodule

/* verif/jsp_tb.sv */
`timescale 1ns/1ps
`include "jsp_consts.svh"

module jsp_tb;

  // Run length, about 20 cycles per operation plus margin
  localparam int NUM_OPS    = 300;
  localparam int MAX_CYCLES = NUM_OPS * 20 + 4000;
  // Debug side needs up to 4 cycles to settle
  localparam int SETTLE     = 5;

  logic              wb_clk_i;
  logic              rst_i;
  jsp_pkg::dbg_req_t dbg_req;
  jsp_pkg::wb_req_t  wb_req;
  jsp_pkg::dbg_rsp_t dbg_rsp;
  jsp_pkg::wb_rsp_t  wb_rsp;
  logic              int_o;
  int                cycles = 0;

  // Reference model
  logic [7:0] rx_q[$];
  logic [7:0] tx_q[$];
  logic [3:0] m_ier;
  logic [7:0] m_lcr;
  logic [7:0] m_scr;
  logic       m_arm;

  jsp_wb_bridge jsp_wb_bridge_i (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .dbg_req_i(dbg_req),
    .wb_req_i (wb_req),
    .dbg_rsp_o(dbg_rsp),
    .wb_rsp_o (wb_rsp),
    .int_o    (int_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  // Watchdog
  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      fail_run("Timeout: the run went past its cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_wb_rsp(input jsp_pkg::wb_rsp_t got, input jsp_pkg::wb_rsp_t exp,
                              input bit chk_dat, input string what);
    if (got.ack !== exp.ack || got.err !== exp.err || (chk_dat && got.dat !== exp.dat)) begin
      fail_run($sformatf("** Error: wb_rsp_o (%s) got dat=%h ack=%h err=%h, exp dat=%h ack=%h err=%h",
                         what, got.dat, got.ack, got.err, exp.dat, exp.ack, exp.err));
    end
  endtask

  task automatic check_dbg_rsp(input jsp_pkg::dbg_rsp_t got, input jsp_pkg::dbg_rsp_t exp,
                               input bit chk_dat);
    if (got.bytes_avail !== exp.bytes_avail || got.bytes_free !== exp.bytes_free ||
        (chk_dat && got.data !== exp.data)) begin
      fail_run($sformatf("** Error: dbg_rsp_o got data=%h avail=%h free=%h, exp data=%h avail=%h free=%h",
                         got.data, got.bytes_avail, got.bytes_free,
                         exp.data, exp.bytes_avail, exp.bytes_free));
    end
  endtask

  task automatic check_int(input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: int_o got %h expected %h", got, exp));
    end
  endtask

  // Cycles from first request cycle to ack
  task automatic check_ack_delay(input int got, input int exp, input string what);
    if (got != exp) begin
      fail_run($sformatf("** Error: wb_rsp_o.ack delay (%s) got %h expected %h", what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Expected values from the register rules
  ////////////////////////////////////////////////////////////

  function automatic logic [7:0] exp_lsr();
    logic tx_nf;
    tx_nf = (tx_q.size() < `JSP_FIFO_DEPTH);
    return {1'b0, tx_nf, tx_nf, 4'h0, rx_q.size() != 0};
  endfunction

  function automatic logic [7:0] exp_iir();
    if (rx_q.size() != 0) begin
      return `JSP_IIR_RX;
    end else if (m_arm && tx_q.size() < `JSP_FIFO_DEPTH) begin
      return `JSP_IIR_THRE;
    end
    return `JSP_IIR_NONE;
  endfunction

  function automatic logic exp_int();
    return ((tx_q.size() < `JSP_FIFO_DEPTH) && m_arm && m_ier[1]) ||
           ((rx_q.size() != 0) && m_ier[0]);
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus and debug port drivers
  ////////////////////////////////////////////////////////////

  // Request held until ack, sampled mid cycle
  task automatic wb_access(input logic we, input logic [2:0] adr, input logic [7:0] dat,
                           output jsp_pkg::wb_rsp_t rsp, output int delay);
    jsp_pkg::wb_req_t req;
    int               waited;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    waited  = 0;
    @(posedge wb_clk_i);
    wb_req <= req;
    @(negedge wb_clk_i);
    while (!wb_rsp.ack && waited < 8) begin
      waited++;
      @(negedge wb_clk_i);
    end
    if (!wb_rsp.ack) begin
      fail_run("Wishbone access got no ack within 8 cycles");
    end
    rsp   = wb_rsp;
    delay = waited;
    @(posedge wb_clk_i);
    wb_req <= '0;
  endtask

  task automatic reg_read(input logic [2:0] adr, input logic [7:0] exp_dat, input string what);
    jsp_pkg::wb_rsp_t rsp;
    jsp_pkg::wb_rsp_t exp;
    int               dly;
    wb_access(1'b0, adr, 8'h00, rsp, dly);
    exp.dat = exp_dat;
    exp.ack = 1'b1;
    exp.err = 1'b0;
    check_wb_rsp(rsp, exp, 1'b1, what);
    check_ack_delay(dly, 0, what);
  endtask

  task automatic reg_write(input logic [2:0] adr, input logic [7:0] dat, input string what);
    jsp_pkg::wb_rsp_t rsp;
    jsp_pkg::wb_rsp_t exp;
    int               dly;
    wb_access(1'b1, adr, dat, rsp, dly);
    exp.dat = 8'h00;
    exp.ack = 1'b1;
    exp.err = 1'b0;
    check_wb_rsp(rsp, exp, 1'b0, what);
    check_ack_delay(dly, 0, what);
  endtask

  // Data read pops rx, acked one cycle late
  task automatic data_read();
    jsp_pkg::wb_rsp_t rsp;
    jsp_pkg::wb_rsp_t exp;
    int               dly;
    wb_access(1'b0, `JSP_ADR_DATA, 8'h00, rsp, dly);
    exp.dat = rx_q.pop_front();
    exp.ack = 1'b1;
    exp.err = 1'b0;
    check_wb_rsp(rsp, exp, 1'b1, "data read");
    check_ack_delay(dly, 1, "data read");
  endtask

  task automatic data_write(input logic [7:0] b);
    jsp_pkg::wb_rsp_t rsp;
    jsp_pkg::wb_rsp_t exp;
    int               dly;
    wb_access(1'b1, `JSP_ADR_DATA, b, rsp, dly);
    exp.dat = 8'h00;
    exp.ack = 1'b1;
    exp.err = 1'b0;
    check_wb_rsp(rsp, exp, 1'b0, "data write");
    check_ack_delay(dly, 1, "data write");
    tx_q.push_back(b);
    m_arm = 1'b1;
  endtask

  // Single cycle strobes
  task automatic dbg_strobe(input logic wr, input logic [7:0] b);
    jsp_pkg::dbg_req_t req;
    req.wr_strobe = wr;
    req.rd_strobe = ~wr;
    req.data      = b;
    @(posedge wb_clk_i);
    dbg_req <= req;
    @(posedge wb_clk_i);
    dbg_req <= '0;
  endtask

  task automatic settle();
    repeat (SETTLE) @(posedge wb_clk_i);
  endtask

  // Debug port, interrupt and LSR against the model
  task automatic check_state();
    jsp_pkg::dbg_rsp_t exp;
    @(negedge wb_clk_i);
    exp.data        = (tx_q.size() != 0) ? tx_q[0] : 8'h00;
    exp.bytes_avail = tx_q.size();
    exp.bytes_free  = `JSP_FIFO_DEPTH - rx_q.size();
    check_dbg_rsp(dbg_rsp, exp, tx_q.size() != 0);
    check_int(int_o, exp_int());
    reg_read(`JSP_ADR_LSR, exp_lsr(), "LSR");
  endtask

  ////////////////////////////////////////////////////////////
  // Random operations
  ////////////////////////////////////////////////////////////

  task automatic op_dbg_writes();
    int         n;
    logic [7:0] b;
    n = $urandom_range(3, 1);
    for (int i = 0; i < n; i++) begin
      // Host writes only with room left
      if (rx_q.size() < `JSP_FIFO_DEPTH) begin
        b = $urandom;
        dbg_strobe(1'b1, b);
        rx_q.push_back(b);
        repeat ($urandom_range(5, 3)) @(posedge wb_clk_i);
      end
    end
  endtask

  task automatic op_bus_reads();
    int n;
    n = $urandom_range(3, 1);
    for (int i = 0; i < n; i++) begin
      reg_read(`JSP_ADR_LSR, exp_lsr(), "LSR before read");
      if (rx_q.size() != 0) begin
        data_read();
      end
    end
  endtask

  task automatic op_bus_writes();
    int n;
    n = $urandom_range(3, 1);
    for (int i = 0; i < n; i++) begin
      reg_read(`JSP_ADR_LSR, exp_lsr(), "LSR before write");
      if (tx_q.size() < `JSP_FIFO_DEPTH) begin
        data_write($urandom);
      end
    end
  endtask

  task automatic op_dbg_reads();
    int n;
    n = $urandom_range(3, 1);
    for (int i = 0; i < n; i++) begin
      if (tx_q.size() != 0) begin
        dbg_strobe(1'b0, 8'h00);
        void'(tx_q.pop_front());
        // Last byte out arms THRE
        if (tx_q.size() == 0) begin
          m_arm = 1'b1;
        end
        settle();
        check_state();
      end
    end
  endtask

  task automatic op_regs();
    logic [7:0] b;
    b = $urandom;
    reg_write(`JSP_ADR_IER, b, "IER write");
    m_ier = b[3:0];
    b = $urandom;
    reg_write(`JSP_ADR_SCR, b, "SCR write");
    m_scr = b;
    reg_read(`JSP_ADR_IER, {4'h0, m_ier}, "IER");
    reg_read(`JSP_ADR_SCR, m_scr, "SCR");
    reg_read(`JSP_ADR_LCR, m_lcr, "LCR");
    reg_read(`JSP_ADR_MCR, 8'h00, "MCR");
    reg_read(`JSP_ADR_MSR, 8'h0b, "MSR");
  endtask

  // DLAB set: IER locked, address 0 is a plain register
  task automatic op_dlab();
    jsp_pkg::wb_rsp_t rsp;
    jsp_pkg::wb_rsp_t exp;
    int               dly;
    m_lcr = $urandom;
    m_lcr[7] = 1'b1;
    reg_write(`JSP_ADR_LCR, m_lcr, "LCR write");
    reg_write(`JSP_ADR_IER, $urandom, "IER write, DLAB");
    reg_read(`JSP_ADR_IER, {4'h0, m_ier}, "IER, DLAB");
    wb_access(1'b0, `JSP_ADR_DATA, 8'h00, rsp, dly);
    exp.dat = (rx_q.size() != 0) ? rx_q[0] : 8'h00;
    exp.ack = 1'b1;
    exp.err = 1'b0;
    check_wb_rsp(rsp, exp, rx_q.size() != 0, "address 0 read, DLAB");
    check_ack_delay(dly, 0, "address 0 read, DLAB");
    wb_access(1'b1, `JSP_ADR_DATA, $urandom, rsp, dly);
    check_wb_rsp(rsp, exp, 1'b0, "address 0 write, DLAB");
    check_ack_delay(dly, 0, "address 0 write, DLAB");
    // Counts must not move
    settle();
    check_state();
    m_lcr = $urandom;
    m_lcr[7] = 1'b0;
    reg_write(`JSP_ADR_LCR, m_lcr, "LCR write");
    reg_read(`JSP_ADR_LCR, m_lcr, "LCR");
  endtask

  task automatic op_fcr();
    logic [7:0] b;
    b = $urandom;
    reg_write(`JSP_ADR_IIR, b, "FCR write");
    if (b[1]) begin
      rx_q.delete();
    end
    if (b[2]) begin
      tx_q.delete();
    end
  endtask

  // IIR read drops the arm bit once rx is empty
  task automatic op_iir();
    reg_read(`JSP_ADR_IIR, exp_iir(), "IIR");
    if (rx_q.size() == 0) begin
      m_arm = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hccd));
    rst_i   = 1'b1;
    dbg_req = '0;
    wb_req  = '0;
    m_ier   = '0;
    m_lcr   = '0;
    m_scr   = '0;
    m_arm   = 1'b0;
    repeat (5) @(posedge wb_clk_i);
    rst_i <= 1'b0;
    settle();
    check_state();
    for (int i = 0; i < NUM_OPS; i++) begin
      // Fills and drains weighted over register work
      case ($urandom_range(12, 0))
        0, 1, 2: op_dbg_writes();
        3, 4:    op_bus_reads();
        5, 6:    op_bus_writes();
        7, 8:    op_dbg_reads();
        9:       op_regs();
        10:      op_dlab();
        11:      op_fcr();
        default: op_iir();
      endcase
      settle();
      check_state();
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* sources.f */
+incdir+rtl
rtl/jsp_pkg.sv
rtl/jsp_byte_fifo.sv
rtl/jsp_fifo_ctrl.sv
rtl/jsp_uart_regs.sv
rtl/jsp_wb_bridge.sv
verif/jsp_tb.sv
